//--- design/dac_ctrl_consts.svh
`ifndef DAC_CTRL_CONSTS_SVH
`define DAC_CTRL_CONSTS_SVH

// Channel layout of the DAC
`define DAC_CHANNELS        8
`define DAC_PAIRS           4  // Two channels per sample word

// Write slot timing in clk cycles
`define DAC_SLOT_CYCLES     42 // Start of one frame to start of the next
`define DAC_SPI_START_DELAY 7  // Slot start to n_cs falling

// SPI framing
`define SPI_FRAME_BITS      24
`define SPI_CMD_REG_WRITE   4'b0001 // Input register write, output updates on LDAC

// Command word fields
`define OPCODE_MSB          31
`define OPCODE_LSB          30
`define TRIG_BIT            29 // Wait for trigger instead of delay
`define CONT_BIT            28 // Another command must follow
`define LDAC_BIT            27 // Pulse LDAC when the command ends
`define DELAY_MSB           24
`define CAL_CH_MSB          18
`define CAL_CH_LSB          16

// Code limits
`define ABS_CAL_MAX         4096
`define DAC_CODE_MID        32767   // Offset code for zero volts
`define DAC_CODE_BAD        16'hFFFF
`define DAC_SIGNED_LIMIT    32767

`endif

//--- design/dac_cmd_pkg.sv
`default_nettype none
`include "dac_ctrl_consts.svh"

package dac_cmd_pkg;

  typedef logic [31:0] cmd_word_t; // One command-buffer word

  // Opcode in the top two bits of a command word
  typedef enum logic [1:0] {
    OP_NOP     = 2'b00, // Delay or trigger wait
    OP_DAC_WR  = 2'b01, // Followed by four sample words
    OP_SET_CAL = 2'b10,
    OP_CANCEL  = 2'b11  // Ends a delay or trigger wait without LDAC
  } opcode_e;

  typedef enum logic [2:0] {
    S_INIT      = 3'd0,
    S_IDLE      = 3'd1,
    S_DELAY     = 3'd2,
    S_TRIG_WAIT = 3'd3,
    S_DAC_WR    = 3'd4,
    S_ERROR     = 3'd5  // Held until reset
  } seq_state_e;

  typedef logic [`DELAY_MSB:0] delay_t; // Delay count in clk cycles
  typedef logic signed [15:0] cal_t;    // Per-channel calibration offset

endpackage

`default_nettype wire

//--- design/dac_spi_pkg.sv
`default_nettype none
`include "dac_ctrl_consts.svh"

package dac_spi_pkg;

  typedef logic [2:0] dac_ch_t;    // DAC channel 0 to 7
  typedef logic [1:0] pair_idx_t;  // Channel pair, even channel is 2*idx
  typedef logic [15:0] dac_code_t; // Offset-coded value, mid scale is zero

  // Calibrated value, one bit wider than the code to hold the overshoot
  typedef logic signed [16:0] dac_val_t;

  typedef logic [`SPI_FRAME_BITS-1:0] spi_frame_t; // Register-write frame

endpackage

`default_nettype wire

//--- design/dac_sample_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dac_sample_if;
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  logic            sample_valid; // One strobe per popped sample word
  dac_code_t [1:0] sample_word;  // Element 0 is the even channel
  pair_idx_t       pair_idx;
  logic            cal_wr;       // Strobe for a set-calibration command
  dac_ch_t         cal_ch;
  cal_t            cal_val;
  logic            val_oob;      // Sticky flags back to the sequencer
  logic            cal_oob;

  modport seq (
    output sample_valid, sample_word, pair_idx, cal_wr, cal_ch, cal_val,
    input  val_oob, cal_oob
  );

  modport cal (
    input  sample_valid, sample_word, pair_idx, cal_wr, cal_ch, cal_val,
    output val_oob, cal_oob
  );

endinterface

`default_nettype wire

//--- design/dac_word_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dac_word_if;
  import dac_spi_pkg::*;

  logic      word_valid; // Strobe, one calibrated pair ready
  pair_idx_t pair_idx;
  dac_code_t code_even;  // Offset code for channel 2*pair_idx
  dac_code_t code_odd;

  modport cal (output word_valid, pair_idx, code_even, code_odd);

  // Writer side, payload stays stable until the next strobe
  modport spi (input word_valid, pair_idx, code_even, code_odd);

endinterface

`default_nettype wire

//--- design/dac_cmd_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "dac_ctrl_consts.svh"

module dac_cmd_sequencer (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire dac_cmd_pkg::cmd_word_t cmd_word,
  input  wire                     cmd_buf_empty,
  input  wire                     trigger,
  input  wire                     ldac_shared,
  input  wire                     pair_done,
  output logic                    cmd_word_rd_en,
  output logic                    setup_done,
  output logic                    waiting_for_trig,
  output logic                    ldac,
  output logic                    cmd_buf_underflow,
  output logic                    unexp_trig,
  output logic                    error_state,
  dac_sample_if.seq               sample
);
  import dac_cmd_pkg::*;

  seq_state_e state;
  seq_state_e state_nxt;
  seq_state_e fetch_state;  // State entered by the command at the buffer head
  opcode_e    cmd_op;
  logic       do_ldac;      // Flags of the running NOP or DAC write
  logic       wait_trig;
  logic       expect_next;
  delay_t     delay_cnt;
  logic [1:0] pair_cnt;     // Pair now in the pipeline or writer
  logic       sample_due;   // Pop a sample word this cycle
  logic       wait_end;
  logic       cmd_end;
  logic       fetch;
  logic       cancel_wait;
  logic       last_pair_done;
  logic       trig_err;
  logic       underflow_err;
  logic       go_err;
  logic       run;          // No error now or on the next edge

  assign cmd_op = opcode_e'(cmd_word[`OPCODE_MSB:`OPCODE_LSB]);

  // Delay or trigger wait finishes this cycle
  assign wait_end = (state == S_DELAY && delay_cnt == '0) ||
                    (state == S_TRIG_WAIT && trigger);
  assign cmd_end = (state == S_IDLE) || wait_end;
  assign fetch = cmd_end && !cmd_buf_empty; // Next command popped in the end cycle

  // A cancel at the head cuts a wait short
  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT) &&
                       !cmd_buf_empty && cmd_op == OP_CANCEL;

  assign last_pair_done = state == S_DAC_WR && pair_done &&
                          pair_cnt == 2'(`DAC_PAIRS - 1);

  // Error sources
  assign trig_err = (trigger && state != S_TRIG_WAIT) ||
                    (ldac_shared && state == S_DAC_WR);   // Shared LDAC mid-write
  assign underflow_err = cmd_buf_empty && ((wait_end && expect_next) || sample_due);
  assign go_err = trig_err || underflow_err || unexp_trig || cmd_buf_underflow ||
                  sample.cal_oob || sample.val_oob;
  assign run = state != S_ERROR && !go_err;

  assign cmd_word_rd_en = run && !cmd_buf_empty && (fetch || cancel_wait || sample_due);
  assign waiting_for_trig = state == S_TRIG_WAIT;
  assign error_state = state == S_ERROR;

  always_comb begin
    case (cmd_op)
      OP_NOP:    fetch_state = cmd_word[`TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
      OP_DAC_WR: fetch_state = S_DAC_WR;
      default:   fetch_state = S_IDLE; // Set-cal and cancel finish at once
    endcase
  end

  always_comb begin
    state_nxt = state;
    if (state != S_ERROR) begin
      if (go_err)
        state_nxt = S_ERROR;
      else if (state == S_INIT)
        state_nxt = S_IDLE;
      else if (cancel_wait)
        state_nxt = S_IDLE;
      else if (fetch)
        state_nxt = fetch_state;
      else if (last_pair_done)
        state_nxt = wait_trig ? S_TRIG_WAIT : S_DELAY; // Wait taken from the write cmd
      else if (wait_end)
        state_nxt = S_IDLE;                            // Ended on an empty buffer
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state               <= S_INIT;
      setup_done          <= 1'b0;
      ldac                <= 1'b0;
      do_ldac             <= 1'b0;
      wait_trig           <= 1'b0;
      expect_next         <= 1'b0;
      delay_cnt           <= '0;
      pair_cnt            <= '0;
      sample_due          <= 1'b0;
      sample.sample_valid <= 1'b0;
      sample.cal_wr       <= 1'b0;
    end else begin
      state      <= state_nxt;
      setup_done <= state_nxt != S_INIT && state_nxt != S_ERROR;
      ldac       <= run && wait_end && do_ldac && !cancel_wait; // No pulse on cancel

      // First sample right after the write command, then one per finished pair
      sample_due <= run && ((fetch && cmd_op == OP_DAC_WR) ||
                            (state == S_DAC_WR && pair_done && !last_pair_done));
      sample.sample_valid <= run && sample_due && !cmd_buf_empty;
      sample.cal_wr       <= run && fetch && cmd_op == OP_SET_CAL;

      if (run && fetch && (cmd_op == OP_NOP || cmd_op == OP_DAC_WR)) begin
        do_ldac     <= cmd_word[`LDAC_BIT];
        wait_trig   <= cmd_word[`TRIG_BIT];
        expect_next <= cmd_word[`CONT_BIT];
        delay_cnt   <= cmd_word[`DELAY_MSB:0]; // Held through a DAC write
      end else if (state == S_DELAY && delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end

      if (run && fetch && cmd_op == OP_DAC_WR)
        pair_cnt <= '0;
      else if (state == S_DAC_WR && pair_done)
        pair_cnt <= pair_cnt + 1'b1;
    end
  end

  // Payload toward the pipeline
  always_ff @(posedge clk) begin
    if (sample_due) begin
      sample.sample_word <= cmd_word;
      sample.pair_idx    <= pair_cnt;
    end
    if (fetch) begin
      sample.cal_ch  <= cmd_word[`CAL_CH_MSB:`CAL_CH_LSB];
      sample.cal_val <= cmd_word[15:0];
    end
  end

  // Sticky error flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
    end else begin
      if (trig_err)
        unexp_trig <= 1'b1;
      if (underflow_err)
        cmd_buf_underflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/dac_cal_pipeline.sv
`timescale 1ns/1ns
`default_nettype none
`include "dac_ctrl_consts.svh"

module dac_cal_pipeline (
  input  wire       clk,
  input  wire       resetn,
  input  wire       error_state,
  output logic      cal_oob,
  output logic      dac_val_oob,
  dac_sample_if.cal sample,
  dac_word_if.cal   word
);
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  cal_t      cal_reg [`DAC_CHANNELS];
  logic      cal_ok;
  logic      code_bad;
  logic      s1_valid;   // Stage 1 holds a converted pair
  pair_idx_t s1_pair;
  dac_val_t  s1_even;
  dac_val_t  s1_odd;
  dac_ch_t   ch_even;
  dac_ch_t   ch_odd;
  dac_val_t  sum_even;
  dac_val_t  sum_odd;
  logic      sum_oob;

  // Offset code to signed, mid scale becomes zero
  function automatic dac_val_t to_signed(dac_code_t code);
    return $signed({1'b0, code}) - dac_val_t'(`DAC_CODE_MID);
  endfunction

  function automatic dac_code_t to_offset(dac_val_t val);
    dac_val_t shifted;
    shifted = val + dac_val_t'(`DAC_CODE_MID);
    return shifted[15:0];
  endfunction

  function automatic logic beyond_limit(dac_val_t val);
    return val > `DAC_SIGNED_LIMIT || val < -`DAC_SIGNED_LIMIT;
  endfunction

  // Calibration registers
  assign cal_ok = sample.cal_val <= `ABS_CAL_MAX && sample.cal_val >= -`ABS_CAL_MAX;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `DAC_CHANNELS; i++)
        cal_reg[i] <= '0;
      cal_oob <= 1'b0;
    end else if (sample.cal_wr && !error_state) begin
      if (cal_ok)
        cal_reg[sample.cal_ch] <= sample.cal_val;
      else
        cal_oob <= 1'b1; // Value dropped, register keeps its old setting
    end
  end

  // Stage 1, reject the forbidden code and convert
  assign code_bad = sample.sample_word[0] == `DAC_CODE_BAD ||
                    sample.sample_word[1] == `DAC_CODE_BAD;

  always_ff @(posedge clk) begin
    if (!resetn)
      s1_valid <= 1'b0;
    else
      s1_valid <= sample.sample_valid && !code_bad && !error_state;
  end

  always_ff @(posedge clk) begin
    if (sample.sample_valid) begin
      s1_pair <= sample.pair_idx;
      s1_even <= to_signed(sample.sample_word[0]);
      s1_odd  <= to_signed(sample.sample_word[1]);
    end
  end

  // Stage 2, add the channel calibration
  assign ch_even  = {s1_pair, 1'b0};
  assign ch_odd   = {s1_pair, 1'b1};
  assign sum_even = s1_even + dac_val_t'(cal_reg[ch_even]); // Sign-extended offset
  assign sum_odd  = s1_odd + dac_val_t'(cal_reg[ch_odd]);
  assign sum_oob  = beyond_limit(sum_even) || beyond_limit(sum_odd);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      word.word_valid <= 1'b0;
      dac_val_oob     <= 1'b0;
    end else begin
      word.word_valid <= s1_valid && !sum_oob && !error_state;
      if ((sample.sample_valid && code_bad) || (s1_valid && sum_oob))
        dac_val_oob <= 1'b1; // Sticky, the sequencer stops on it
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      word.pair_idx  <= s1_pair;
      word.code_even <= to_offset(sum_even);
      word.code_odd  <= to_offset(sum_odd);
    end
  end

  assign sample.cal_oob = cal_oob;
  assign sample.val_oob = dac_val_oob;

endmodule

`default_nettype wire

//--- design/dac_spi_writer.sv
`timescale 1ns/1ns
`default_nettype none
`include "dac_ctrl_consts.svh"

module dac_spi_writer (
  input  wire       clk,
  input  wire       resetn,
  input  wire       error_state,
  output logic      n_cs,
  output logic      mosi,
  output logic      pair_done,
  dac_word_if.spi   word
);
  import dac_spi_pkg::*;

  logic       busy;       // Pair slot in progress
  logic [6:0] slot_cnt;   // Cycles since word_valid
  logic [4:0] bit_cnt;    // Bits left after the current one
  spi_frame_t shreg;
  pair_idx_t  pair_q;
  dac_code_t  code_even_q;
  dac_code_t  code_odd_q;
  logic       start_even;
  logic       start_odd;
  logic       slot_end;

  // Command nibble, zero bit, channel, code
  function automatic spi_frame_t make_frame(dac_ch_t ch, dac_code_t code);
    return {`SPI_CMD_REG_WRITE, 1'b0, ch, code};
  endfunction

  assign start_even = busy && slot_cnt == 7'(`DAC_SPI_START_DELAY - 1);
  assign start_odd  = busy && slot_cnt == 7'(`DAC_SPI_START_DELAY + `DAC_SLOT_CYCLES - 1);
  assign slot_end   = busy && slot_cnt == 7'(2 * `DAC_SLOT_CYCLES - 1);
  assign mosi       = shreg[`SPI_FRAME_BITS-1]; // MSB first

  // Slot timer
  always_ff @(posedge clk) begin
    if (!resetn || error_state) begin
      busy      <= 1'b0;
      slot_cnt  <= '0;
      pair_done <= 1'b0;
    end else begin
      pair_done <= slot_end;
      if (word.word_valid) begin
        busy     <= 1'b1;
        slot_cnt <= 7'd1;
      end else if (busy) begin
        if (slot_end)
          busy <= 1'b0;
        slot_cnt <= slot_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word.word_valid) begin
      pair_q      <= word.pair_idx;
      code_even_q <= word.code_even;
      code_odd_q  <= word.code_odd;
    end
  end

  // Shift register and chip select
  always_ff @(posedge clk) begin
    if (!resetn || error_state) begin
      n_cs    <= 1'b1;
      bit_cnt <= '0;
      shreg   <= '0;
    end else if (start_even || start_odd) begin
      n_cs    <= 1'b0;
      bit_cnt <= 5'(`SPI_FRAME_BITS - 1);
      shreg   <= start_even ? make_frame({pair_q, 1'b0}, code_even_q)
                            : make_frame({pair_q, 1'b1}, code_odd_q);
    end else if (!n_cs) begin
      shreg <= shreg << 1;
      if (bit_cnt == '0)
        n_cs <= 1'b1; // Last bit done
      else
        bit_cnt <= bit_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/ad5676_dac_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module ad5676_dac_ctrl (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire dac_cmd_pkg::cmd_word_t cmd_word,
  input  wire                     cmd_buf_empty,
  input  wire                     trigger,
  input  wire                     ldac_shared,
  output logic                    cmd_word_rd_en,
  output logic                    setup_done,
  output logic                    waiting_for_trig,
  output logic                    cmd_buf_underflow,
  output logic                    unexp_trig,
  output logic                    cal_oob,
  output logic                    dac_val_oob,
  output logic                    n_cs,
  output logic                    mosi,
  output logic                    ldac
);

  logic pair_done;   // Writer finished both frames of a pair
  logic error_state;

  dac_sample_if u_sample_if ();
  dac_word_if   u_word_if ();

  dac_cmd_sequencer u_seq (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .trigger           (trigger),
    .ldac_shared       (ldac_shared),
    .pair_done         (pair_done),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .setup_done        (setup_done),
    .waiting_for_trig  (waiting_for_trig),
    .ldac              (ldac),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig),
    .error_state       (error_state),
    .sample            (u_sample_if.seq)
  );

  dac_cal_pipeline u_cal (
    .clk         (clk),
    .resetn      (resetn),
    .error_state (error_state),
    .cal_oob     (cal_oob),
    .dac_val_oob (dac_val_oob),
    .sample      (u_sample_if.cal),
    .word        (u_word_if.cal)
  );

  dac_spi_writer u_spi (
    .clk         (clk),
    .resetn      (resetn),
    .error_state (error_state),
    .n_cs        (n_cs),
    .mosi        (mosi),
    .pair_done   (pair_done),
    .word        (u_word_if.spi)
  );

endmodule

`default_nettype wire

//--- test/tb_ad5676_dac_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "dac_ctrl_consts.svh"

module tb_ad5676_dac_ctrl;
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int WRITE_CYCLES = `DAC_PAIRS * 2 * `DAC_SLOT_CYCLES + 64; // One full DAC write
  // Ten resets, two full writes, six short tests, times a wide margin
  localparam int TEST_CYCLES = 10 * (RESET_CYCLES + 4) + 2 * (WRITE_CYCLES + 100) + 6 * 200;
  localparam int WATCHDOG_CYCLES = 8 * TEST_CYCLES;

  logic      clk = 1'b0;
  logic      resetn;
  cmd_word_t cmd_word;
  logic      cmd_buf_empty;
  logic      trigger;
  logic      ldac_shared;
  logic      cmd_word_rd_en;
  logic      setup_done;
  logic      waiting_for_trig;
  logic      cmd_buf_underflow;
  logic      unexp_trig;
  logic      cal_oob;
  logic      dac_val_oob;
  logic      n_cs;
  logic      mosi;
  logic      ldac;

  cmd_word_t  cmd_q[$];       // Show-ahead command buffer model
  logic       pop_pending = 1'b0;
  spi_frame_t frames[$];      // Captured SPI frames
  spi_frame_t frame_sr;
  int         frame_bits = 0;
  int         ldac_count = 0;
  logic       ldac_q = 1'b0;
  int         cyc = 0;        // Rising edges since time zero
  int         pop_cyc = 0;    // Edge of the latest pop
  int         ldac_cyc = 0;   // Edge before the latest ldac pulse
  int         seed;
  int         n_checks = 0;
  int         n_fail = 0;
  int         n_timeout = 0;

  ad5676_dac_ctrl u_ad5676_dac_ctrl (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .trigger           (trigger),
    .ldac_shared       (ldac_shared),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .setup_done        (setup_done),
    .waiting_for_trig  (waiting_for_trig),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig),
    .cal_oob           (cal_oob),
    .dac_val_oob       (dac_val_oob),
    .n_cs              (n_cs),
    .mosi              (mosi),
    .ldac              (ldac)
  );

  always #10 clk = ~clk; // 20 ns period

  always @(posedge clk) cyc = cyc + 1;

  // Read enable is stable at the falling edge and acts on the next rising edge
  always @(negedge clk) pop_pending = (cmd_word_rd_en === 1'b1);

  // Buffer model, head and empty flag change 2 ns after the edge
  always @(posedge clk) begin
    #2;
    if (pop_pending && cmd_q.size() > 0) begin
      void'(cmd_q.pop_front());
      pop_cyc = cyc;
    end
    cmd_buf_empty = cmd_q.size() == 0;
    cmd_word = (cmd_q.size() > 0) ? cmd_q[0] : '0;
  end

  // SPI capture, MSB first while n_cs is low
  always @(negedge clk) begin
    if (n_cs === 1'b0) begin
      frame_sr = {frame_sr[`SPI_FRAME_BITS-2:0], mosi};
      frame_bits = frame_bits + 1;
      if (frame_bits == `SPI_FRAME_BITS) begin
        frames.push_back(frame_sr);
        frame_bits = 0;
      end
    end else begin
      frame_bits = 0;
    end
  end

  // Count rising edges of ldac
  always @(negedge clk) begin
    if (ldac === 1'b1 && ldac_q !== 1'b1) begin
      ldac_count = ldac_count + 1;
      ldac_cyc = cyc;
    end
    ldac_q = ldac;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic cmd_word_t make_cmd(opcode_e op, logic trig, logic cont, logic do_ldac,
                                         delay_t delay);
    cmd_word_t w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = op;
    w[`TRIG_BIT] = trig;
    w[`CONT_BIT] = cont;
    w[`LDAC_BIT] = do_ldac;
    w[`DELAY_MSB:0] = delay;
    return w;
  endfunction

  function automatic cmd_word_t cal_cmd(dac_ch_t ch, cal_t val);
    cmd_word_t w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = OP_SET_CAL;
    w[`CAL_CH_MSB:`CAL_CH_LSB] = ch;
    w[15:0] = val;
    return w;
  endfunction

  // Register write, zero bit, channel, code
  function automatic spi_frame_t frame_for(dac_ch_t ch, dac_code_t code);
    return {4'b0001, 1'b0, ch, code};
  endfunction

  function automatic dac_code_t rand_code(int lo, int hi);
    int unsigned r;
    r = $unsigned($random(seed));
    return dac_code_t'(lo + int'(r % (hi - lo + 1)));
  endfunction

  function automatic logic probe(string name);
    case (name)
      "setup_done":        return setup_done;
      "waiting_for_trig":  return waiting_for_trig;
      "cmd_buf_underflow": return cmd_buf_underflow;
      "unexp_trig":        return unexp_trig;
      "cal_oob":           return cal_oob;
      "dac_val_oob":       return dac_val_oob;
      "n_cs":              return n_cs;
      default:             return 1'bx;
    endcase
  endfunction

  task automatic check_frame(spi_frame_t got, spi_frame_t exp, string what);
    n_checks++;
    if (got !== exp) begin
      n_fail++;
      $display("FAIL @%0t: %s frame %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_code(dac_code_t got, dac_code_t exp, string what);
    n_checks++;
    if (got !== exp) begin
      n_fail++;
      $display("FAIL @%0t: %s code %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    n_checks++;
    if (got !== exp) begin
      n_fail++;
      $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_delay(delay_t got, delay_t exp, string what);
    n_checks++;
    if (got !== exp) begin
      n_fail++;
      $display("FAIL @%0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    n_checks++;
    if (got != exp) begin
      n_fail++;
      $display("FAIL @%0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    n_timeout++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  task automatic wait_signal(string name, logic level, int limit);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (probe(name) !== level && t < limit);
    if (probe(name) !== level)
      report_timeout({name, " to change"});
  endtask

  task automatic wait_frames(int n, int limit);
    int t;
    t = 0;
    while (frames.size() < n && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (frames.size() < n)
      report_timeout("SPI frames");
  endtask

  task automatic wait_ldac(int n, int limit);
    int t;
    t = 0;
    while (ldac_count < n && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (ldac_count < n)
      report_timeout("an ldac pulse");
  endtask

  // Buffer emptied on a falling edge, DUT inputs 2 ns after a rising edge
  task automatic apply_reset();
    @(negedge clk);
    cmd_q.delete();
    @(posedge clk);
    #2;
    resetn = 1'b0;
    trigger = 1'b0;
    ldac_shared = 1'b0;
    frames.delete();
    ldac_count = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    resetn = 1'b1;
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    #2;
    trigger = 1'b1;
    @(posedge clk);
    #2;
    trigger = 1'b0;
  endtask

  task automatic pulse_ldac_shared();
    @(posedge clk);
    #2;
    ldac_shared = 1'b1;
    @(posedge clk);
    #2;
    ldac_shared = 1'b0;
  endtask

  // Write command plus four sample words, low half is the even channel
  task automatic push_write(logic do_ldac, delay_t delay, dac_code_t codes[8]);
    cmd_q.push_back(make_cmd(OP_DAC_WR, 1'b0, 1'b0, do_ldac, delay));
    for (int p = 0; p < `DAC_PAIRS; p++)
      cmd_q.push_back({codes[2*p+1], codes[2*p]});
  endtask

  // Flag set, controller stopped, no SPI traffic after it
  task automatic expect_error(string name);
    int low_cycles;
    low_cycles = 0;
    wait_signal(name, 1'b1, 100);
    wait_signal("setup_done", 1'b0, 10);
    check_flag(probe(name), 1'b1, name);
    check_flag(setup_done, 1'b0, "setup_done in error");
    @(posedge clk);
    #2;
    frames.delete();
    repeat (100) begin
      @(negedge clk);
      if (n_cs !== 1'b1)
        low_cycles++;
    end
    check_count(low_cycles, 0, "n_cs low cycles after error");
    check_count(frames.size(), 0, "frames after error");
  endtask

  task automatic test_reset();
    apply_reset();
    wait_signal("setup_done", 1'b1, 4);
    check_flag(n_cs, 1'b1, "n_cs");
    check_flag(ldac, 1'b0, "ldac");
    check_flag(cmd_word_rd_en, 1'b0, "cmd_word_rd_en");
    check_flag(waiting_for_trig, 1'b0, "waiting_for_trig");
    check_flag(cmd_buf_underflow, 1'b0, "cmd_buf_underflow");
    check_flag(unexp_trig, 1'b0, "unexp_trig");
    check_flag(cal_oob, 1'b0, "cal_oob");
    check_flag(dac_val_oob, 1'b0, "dac_val_oob");
  endtask

  task automatic test_delay_ldac();
    apply_reset();
    @(negedge clk);
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b0, 1'b1, 50));
    wait_ldac(1, 200);
    repeat (20) @(negedge clk);   // Room for a stray second pulse
    check_count(ldac_count, 1, "ldac pulses");
    check_delay(delay_t'(ldac_cyc - pop_cyc), 51, "pop to ldac");
  endtask

  task automatic test_write_plain();
    dac_code_t codes[8];
    apply_reset();
    for (int i = 0; i < `DAC_CHANNELS; i++)
      codes[i] = rand_code(1, 65534);
    @(negedge clk);
    push_write(1'b1, 5, codes);
    wait_frames(`DAC_CHANNELS, WRITE_CYCLES);
    wait_ldac(1, 100);
    check_count(frames.size(), `DAC_CHANNELS, "frames");
    for (int i = 0; i < frames.size() && i < `DAC_CHANNELS; i++)
      check_frame(frames[i], frame_for(dac_ch_t'(i), codes[i]), $sformatf("ch%0d", i));
    check_count(ldac_count, 1, "ldac pulses after write");
  endtask

  task automatic test_write_cal();
    dac_code_t codes[8];
    cal_t      cal[8];
    dac_code_t exp_code;
    apply_reset();
    for (int i = 0; i < `DAC_CHANNELS; i++) begin
      cal[i] = '0;
      codes[i] = rand_code(`ABS_CAL_MAX, 65534 - `ABS_CAL_MAX); // Sum stays in range
    end
    cal[0] = 100;
    cal[1] = -250;
    cal[3] = `ABS_CAL_MAX;      // Both limits are legal
    cal[4] = -`ABS_CAL_MAX;
    cal[6] = 1234;
    @(negedge clk);
    for (int i = 0; i < `DAC_CHANNELS; i++)
      if (cal[i] != 0)
        cmd_q.push_back(cal_cmd(dac_ch_t'(i), cal[i]));
    push_write(1'b0, 5, codes);
    wait_frames(`DAC_CHANNELS, WRITE_CYCLES);
    check_count(frames.size(), `DAC_CHANNELS, "calibrated frames");
    for (int i = 0; i < frames.size() && i < `DAC_CHANNELS; i++) begin
      exp_code = dac_code_t'(int'(codes[i]) + int'(cal[i]));
      check_code(frames[i][15:0], exp_code, $sformatf("calibrated ch%0d", i));
    end
  endtask

  task automatic test_trigger();
    apply_reset();
    @(negedge clk);
    cmd_q.push_back(make_cmd(OP_NOP, 1'b1, 1'b0, 1'b1, 0));
    wait_signal("waiting_for_trig", 1'b1, 20);
    check_flag(waiting_for_trig, 1'b1, "waiting_for_trig");
    pulse_trigger();
    wait_ldac(1, 20);
    wait_signal("waiting_for_trig", 1'b0, 20);
    check_count(ldac_count, 1, "ldac pulses on trigger");
    // Cancel the next wait, so no pulse
    @(negedge clk);
    cmd_q.push_back(make_cmd(OP_NOP, 1'b1, 1'b0, 1'b1, 0));
    wait_signal("waiting_for_trig", 1'b1, 20);
    @(negedge clk);
    cmd_q.push_back(make_cmd(OP_CANCEL, 1'b0, 1'b0, 1'b0, 0));
    wait_signal("waiting_for_trig", 1'b0, 20);
    repeat (10) @(negedge clk);
    check_count(ldac_count, 1, "ldac pulses after cancel");
    check_count(cmd_q.size(), 0, "commands left");
    // Trigger with nothing waiting
    check_flag(setup_done, 1'b1, "setup_done before idle trigger");
    pulse_trigger();
    wait_signal("unexp_trig", 1'b1, 20);
    wait_signal("setup_done", 1'b0, 10);
    check_flag(unexp_trig, 1'b1, "unexp_trig");
    check_flag(setup_done, 1'b0, "setup_done after idle trigger");
    check_flag(n_cs, 1'b1, "n_cs after idle trigger");
  endtask

  task automatic test_errors();
    dac_code_t codes[8];
    for (int i = 0; i < `DAC_CHANNELS; i++)
      codes[i] = 16'h4000 + 16'(i);
    apply_reset();
    @(negedge clk);
    cmd_q.push_back(cal_cmd(2, 5000));
    expect_error("cal_oob");

    apply_reset();
    codes[0] = `DAC_CODE_BAD;           // Forbidden code in the even half
    @(negedge clk);
    push_write(1'b0, 5, codes);
    expect_error("dac_val_oob");

    apply_reset();
    codes[0] = 16'd65534;               // Plus 100 goes past full scale
    @(negedge clk);
    cmd_q.push_back(cal_cmd(0, 100));
    push_write(1'b0, 5, codes);
    expect_error("dac_val_oob");

    apply_reset();
    @(negedge clk);
    cmd_q.push_back(make_cmd(OP_NOP, 1'b0, 1'b1, 1'b0, 10)); // Continue flag, nothing follows
    expect_error("cmd_buf_underflow");

    apply_reset();
    codes[0] = 16'h4000;
    @(negedge clk);
    push_write(1'b0, 5, codes);
    wait_signal("n_cs", 1'b0, WRITE_CYCLES);
    pulse_ldac_shared();                // Shared LDAC while a frame shifts out
    expect_error("unexp_trig");
  endtask

  initial begin
    resetn = 1'b0;
    cmd_word = '0;
    cmd_buf_empty = 1'b1;
    trigger = 1'b0;
    ldac_shared = 1'b0;
    seed = 74202;
    test_reset();
    test_delay_ldac();
    test_write_plain();
    test_write_cal();
    test_trigger();
    test_errors();
    $display("Checks: %0d, value errors: %0d, timeouts: %0d", n_checks, n_fail, n_timeout);
    if (n_fail == 0 && n_timeout == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/dac_cmd_pkg.sv
design/dac_spi_pkg.sv
design/dac_sample_if.sv
design/dac_word_if.sv
design/dac_cmd_sequencer.sv
design/dac_cal_pipeline.sv
design/dac_spi_writer.sv
design/ad5676_dac_ctrl.sv
test/tb_ad5676_dac_ctrl.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ad5676_dac_ctrl
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
